/* files.f */
hdl/cmd_pkg.sv
hdl/axil_pkg.sv
hdl/hdr_collector.sv
hdl/cmd_sequencer.sv
hdl/axil_port.sv
hdl/master_cfg_regs.sv
hdl/cmd_master_top.sv
dv/cmd_master_props.sv
dv/cmd_master_tb.sv

/* dv/cmd_master_tb.sv */
// Memory model holds 64 words below byte address 0x100; addresses from 0x1000 answer SLVERR
`timescale 1ns/1ps
`default_nettype none

module cmd_master_tb;
  import cmd_pkg::*;
  import axil_pkg::*;

  localparam int         TIMEOUT   = 500;  // Cycles per wait
  localparam int         MEM_WORDS = 64;
  localparam axil_addr_t ERR_BASE  = 32'h1000;
  localparam int         BIT_PING  = 1;    // Status bit positions
  localparam int         BIT_WRITE = 2;
  localparam int         BIT_READ  = 3;
  localparam int         BIT_CFG_WR = 4;
  localparam int         BIT_CFG_RD = 5;
  localparam int         BIT_UNREC = 8;

  logic       clk;
  logic       w_rst;
  logic       in_valid;
  word_t      in_data;
  logic       out_ready;
  logic       awready;
  logic       wready;
  logic       bvalid;
  axil_resp_t bresp;
  logic       arready;
  logic       rvalid;
  axil_data_t rdata;
  axil_resp_t rresp;

  logic       o_in_ready;
  logic       o_out_valid;
  word_t      o_out_data;
  logic       o_out_last;
  logic       o_awvalid;
  axil_addr_t o_awaddr;
  logic       o_wvalid;
  axil_data_t o_wdata;
  axil_strb_t o_wstrb;
  logic       o_bready;
  logic       o_arvalid;
  axil_addr_t o_araddr;
  logic       o_rready;

  axil_data_t mem [MEM_WORDS];
  word_t      known_words [4];  // Last full-strobe write, used by the mask test
  int         errors = 0;
  int         checks = 0;
  int         tests = 0;
  logic       timed_out = 1'b0;

  cmd_master_top cmd_master_top_inst (
    .clk         (clk),
    .w_rst       (w_rst),
    .i_in_valid  (in_valid),
    .i_in_data   (in_data),
    .o_in_ready  (o_in_ready),
    .o_out_valid (o_out_valid),
    .o_out_data  (o_out_data),
    .o_out_last  (o_out_last),
    .i_out_ready (out_ready),
    .o_awvalid   (o_awvalid),
    .o_awaddr    (o_awaddr),
    .i_awready   (awready),
    .o_wvalid    (o_wvalid),
    .o_wdata     (o_wdata),
    .o_wstrb     (o_wstrb),
    .i_wready    (wready),
    .i_bvalid    (bvalid),
    .i_bresp     (bresp),
    .o_bready    (o_bready),
    .o_arvalid   (o_arvalid),
    .o_araddr    (o_araddr),
    .i_arready   (arready),
    .i_rvalid    (rvalid),
    .i_rdata     (rdata),
    .i_rresp     (rresp),
    .o_rready    (o_rready)
  );

  always #2 clk = ~clk;

  task automatic flag_timeout(input string what);
    if (!timed_out) begin
      $display("timeout while waiting for %s", what);
      errors++;
    end
    timed_out = 1'b1;
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp)
    else begin
      errors++;
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Complete bit plus one kind bit and the bus response field
  function automatic word_t expected_status(input int kind_bit, input axil_resp_t bus);
    word_t w;
    w = 32'h1 | (32'h1 << kind_bit);
    w[7:6] = bus;
    return w;
  endfunction

  // Called on a falling edge, returns on the falling edge after the word is taken
  task automatic send_word(input word_t w);
    int t;
    if (timed_out) return;
    in_valid = 1'b1;
    in_data  = w;
    t = 0;
    while (!o_in_ready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!o_in_ready) flag_timeout("ingress ready");
    else @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic send_cmd(input cmd_code_t code, input cmd_flags_t flags, input word_t count,
                          input word_t addr, input word_t pay[$]);
    int i;
    send_word({code, flags});
    send_word(count);
    send_word(addr);
    for (i = 0; i < pay.size(); i++) begin
      send_word(pay[i]);
    end
  endtask

  // Random back-pressure on egress until the last word
  task automatic recv_response(output word_t q[$]);
    int   t;
    logic done;
    q    = {};
    done = 1'b0;
    t    = 0;
    while (!done && !timed_out && t < TIMEOUT) begin
      out_ready = ($urandom_range(3, 0) != 0);
      if (o_out_valid && out_ready) begin
        q.push_back(o_out_data);
        done = o_out_last;
      end
      @(negedge clk);
      t++;
    end
    out_ready = 1'b0;
    if (!done) flag_timeout("egress last word");
  endtask

  task automatic compare_response(input string what, input word_t got[$], input word_t exp[$]);
    int i;
    check_value({what, " response length"}, got.size(), exp.size());
    for (i = 0; i < exp.size() && i < got.size(); i++) begin
      check_value($sformatf("%s o_out_data[%0d]", what, i), got[i], exp[i]);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    $display("%s finished with %0d errors", name, errors - err0);
  endtask

  task automatic serve_write();
    int         da;
    int         dw;
    int         c;
    int         t;
    int         b;
    axil_addr_t a;
    axil_data_t d;
    axil_strb_t s;
    logic       aw_done;
    logic       w_done;
    da      = $urandom_range(3, 0);
    dw      = $urandom_range(3, 0);
    aw_done = 1'b0;
    w_done  = 1'b0;
    c       = 0;
    // Address and data accepted on independent delays
    while (!(aw_done && w_done) && c < TIMEOUT) begin
      awready = !aw_done && o_awvalid && (c >= da);
      wready  = !w_done && o_wvalid && (c >= dw);
      if (awready) begin
        a       = o_awaddr;
        aw_done = 1'b1;
      end
      if (wready) begin
        d      = o_wdata;
        s      = o_wstrb;
        w_done = 1'b1;
      end
      @(negedge clk);
      c++;
    end
    awready = 1'b0;
    wready  = 1'b0;
    if (!(aw_done && w_done)) begin
      flag_timeout("write address and data");
      return;
    end
    if (a >= ERR_BASE) begin
      bresp = RESP_SLVERR;
    end else begin
      bresp = RESP_OKAY;
      for (b = 0; b < 4; b++) begin
        if (s[b]) mem[a[7:2]][8*b +: 8] = d[8*b +: 8];
      end
    end
    repeat ($urandom_range(3, 0)) @(negedge clk);
    bvalid = 1'b1;
    t = 0;
    while (!o_bready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!o_bready) flag_timeout("bready");
    else @(negedge clk);
    bvalid = 1'b0;
  endtask

  task automatic serve_read();
    int         t;
    axil_addr_t a;
    repeat ($urandom_range(3, 0)) @(negedge clk);
    arready = 1'b1;
    a       = o_araddr;
    @(negedge clk);
    arready = 1'b0;
    repeat ($urandom_range(3, 0)) @(negedge clk);
    if (a >= ERR_BASE) begin
      rresp = RESP_SLVERR;
      rdata = '0;
    end else begin
      rresp = RESP_OKAY;
      rdata = mem[a[7:2]];
    end
    rvalid = 1'b1;
    t = 0;
    while (!o_rready && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!o_rready) flag_timeout("rready");
    else @(negedge clk);
    rvalid = 1'b0;
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (!w_rst && o_awvalid) serve_write();
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (!w_rst && o_arvalid) serve_read();
    end
  end

  task automatic ping_roundtrip(input string name);
    int    err0;
    word_t none[$];
    word_t got[$];
    word_t exp[$];
    err0 = errors;
    send_cmd(CMD_PING, '0, 32'd0, 32'd0, none);
    recv_response(got);
    exp.push_back(expected_status(BIT_PING, RESP_OKAY));
    compare_response(name, got, exp);
    report_test(name, err0);
  endtask

  task automatic cfg_write_read();
    int         err0;
    cmd_flags_t f;
    word_t      none[$];
    word_t      pay[$];
    word_t      got[$];
    word_t      exp[$];
    err0 = errors;
    f = '0;
    f[FLAG_CFG_SPACE] = 1'b1;
    pay.push_back(32'h1);  // Write response on
    pay.push_back(32'hF);
    send_cmd(CMD_WRITE, f, 32'd2, 32'd0, pay);
    recv_response(got);
    exp.push_back(expected_status(BIT_CFG_WR, RESP_OKAY));
    compare_response("config write", got, exp);
    exp = {};
    send_cmd(CMD_READ, f, 32'd3, 32'd0, none);
    recv_response(got);
    exp.push_back(32'h1);
    exp.push_back(32'hF);
    exp.push_back(32'h0);  // Unused address
    exp.push_back(expected_status(BIT_CFG_RD, RESP_OKAY));
    compare_response("config read", got, exp);
    report_test("config access", err0);
  endtask

  task automatic bus_write_readback();
    int    err0;
    int    i;
    word_t none[$];
    word_t pay[$];
    word_t got[$];
    word_t exp[$];
    err0 = errors;
    for (i = 0; i < 4; i++) begin
      known_words[i] = $urandom;
      pay.push_back(known_words[i]);
    end
    send_cmd(CMD_WRITE, '0, 32'd4, 32'd0, pay);
    recv_response(got);
    exp.push_back(expected_status(BIT_WRITE, RESP_OKAY));
    compare_response("bus write", got, exp);
    exp = {};
    send_cmd(CMD_READ, '0, 32'd4, 32'd0, none);
    recv_response(got);
    for (i = 0; i < 4; i++) begin
      exp.push_back(known_words[i]);
    end
    exp.push_back(expected_status(BIT_READ, RESP_OKAY));
    compare_response("bus read", got, exp);
    report_test("bus write and read", err0);
  endtask

  task automatic strobe_masking();
    int         err0;
    int         i;
    cmd_flags_t f;
    word_t      none[$];
    word_t      pay[$];
    word_t      fresh[$];
    word_t      got[$];
    word_t      exp[$];
    err0 = errors;
    f = '0;
    f[FLAG_CFG_SPACE] = 1'b1;
    pay.push_back(32'h3);  // Low two byte lanes only
    send_cmd(CMD_WRITE, f, 32'd1, 32'd1, pay);
    recv_response(got);
    exp.push_back(expected_status(BIT_CFG_WR, RESP_OKAY));
    compare_response("strobe setup", got, exp);
    exp = {};
    for (i = 0; i < 4; i++) begin
      fresh.push_back($urandom);
    end
    send_cmd(CMD_WRITE, '0, 32'd4, 32'd0, fresh);
    recv_response(got);
    exp.push_back(expected_status(BIT_WRITE, RESP_OKAY));
    compare_response("masked write", got, exp);
    exp = {};
    send_cmd(CMD_READ, '0, 32'd4, 32'd0, none);
    recv_response(got);
    for (i = 0; i < 4; i++) begin
      exp.push_back({known_words[i][31:16], fresh[i][15:0]});
    end
    exp.push_back(expected_status(BIT_READ, RESP_OKAY));
    compare_response("masked read", got, exp);
    report_test("strobe mask", err0);
  endtask

  task automatic error_region_read();
    int    err0;
    word_t none[$];
    word_t got[$];
    word_t exp[$];
    err0 = errors;
    send_cmd(CMD_READ, '0, 32'd1, ERR_BASE, none);
    recv_response(got);
    exp.push_back(32'h0);  // Model returns zero data on an error
    exp.push_back(expected_status(BIT_READ, RESP_SLVERR));
    compare_response("error read", got, exp);
    report_test("error region", err0);
  endtask

  task automatic unknown_cmd_drop();
    int    err0;
    word_t pay[$];
    word_t got[$];
    word_t exp[$];
    err0 = errors;
    pay.push_back($urandom);
    pay.push_back($urandom);
    send_cmd(16'h0007, '0, 32'd2, 32'd0, pay);
    recv_response(got);
    exp.push_back(expected_status(BIT_UNREC, RESP_OKAY));
    compare_response("unknown command", got, exp);
    report_test("unknown command", err0);
    ping_roundtrip("ping after drop");
  endtask

  task automatic finish_run();
    int prop_fails;
    prop_fails = cmd_master_top_inst.props_inst.fail_cnt;
    $display("summary: %0d tests, %0d checks, %0d errors, %0d property failures",
             tests, checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0 && !timed_out) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  initial begin
    int i;
    void'($urandom(32'h8837));
    clk       = 1'b0;
    w_rst     = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    awready   = 1'b0;
    wready    = 1'b0;
    bvalid    = 1'b0;
    bresp     = RESP_OKAY;
    arready   = 1'b0;
    rvalid    = 1'b0;
    rdata     = '0;
    rresp     = RESP_OKAY;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hA5000000 ^ (i * 32'h01010101);
    end
    repeat (4) @(negedge clk);
    w_rst = 1'b0;
    @(negedge clk);
    if (!timed_out) ping_roundtrip("ping");
    if (!timed_out) cfg_write_read();
    if (!timed_out) bus_write_readback();
    if (!timed_out) strobe_masking();
    if (!timed_out) error_region_read();
    if (!timed_out) unknown_cmd_drop();
    repeat (4) @(negedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

/* dv/cmd_master_props.sv */
// Handshake rules for cmd_master_top; checks other than the reset one are off while w_rst is high
`timescale 1ns/1ps
`default_nettype none

module cmd_master_props (
  input logic           clk,
  input logic           w_rst,
  input logic           o_in_ready,
  input logic           o_out_valid,
  input cmd_pkg::word_t o_out_data,
  input logic           o_out_last,
  input logic           i_out_ready,
  input logic           o_awvalid,
  input logic           i_awready,
  input logic           o_wvalid,
  input logic           i_wready,
  input logic           o_bready,
  input logic           o_arvalid,
  input logic           i_arready,
  input logic           o_rready
);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end

  aw_hold: assert property (@(posedge clk) disable iff (w_rst)
      o_awvalid && !i_awready |=> o_awvalid)
    else begin
      fail_cnt++;
      $error("awvalid dropped before awready");
    end

  w_hold: assert property (@(posedge clk) disable iff (w_rst)
      o_wvalid && !i_wready |=> o_wvalid)
    else begin
      fail_cnt++;
      $error("wvalid dropped before wready");
    end

  ar_hold: assert property (@(posedge clk) disable iff (w_rst)
      o_arvalid && !i_arready |=> o_arvalid)
    else begin
      fail_cnt++;
      $error("arvalid dropped before arready");
    end

  // Stalled egress word must not change
  out_stable: assert property (@(posedge clk) disable iff (w_rst)
      o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data) && $stable(o_out_last))
    else begin
      fail_cnt++;
      $error("egress word changed while stalled");
    end

  reset_quiet: assert property (@(posedge clk)
      w_rst |=> !o_out_valid && !o_in_ready && !o_awvalid && !o_wvalid && !o_bready
                && !o_arvalid && !o_rready)
    else begin
      fail_cnt++;
      $error("handshake output high during reset");
    end

endmodule

bind cmd_master_top cmd_master_props props_inst (
  .clk         (clk),
  .w_rst       (w_rst),
  .o_in_ready  (o_in_ready),
  .o_out_valid (o_out_valid),
  .o_out_data  (o_out_data),
  .o_out_last  (o_out_last),
  .i_out_ready (i_out_ready),
  .o_awvalid   (o_awvalid),
  .i_awready   (i_awready),
  .o_wvalid    (o_wvalid),
  .i_wready    (i_wready),
  .o_bready    (o_bready),
  .o_arvalid   (o_arvalid),
  .i_arready   (i_arready),
  .o_rready    (o_rready)
);

`default_nettype wire

/* hdl/cmd_master_top.sv */
// Single clock, one AXI4-Lite transaction in flight; host must hold ingress words until taken
`timescale 1ns/1ps
`default_nettype none

module cmd_master_top (
  input  logic                 clk,
  input  logic                 w_rst,
  // Host ingress
  input  logic                 i_in_valid,
  input  cmd_pkg::word_t       i_in_data,
  output logic                 o_in_ready,
  // Host egress
  output logic                 o_out_valid,
  output cmd_pkg::word_t       o_out_data,
  output logic                 o_out_last,
  input  logic                 i_out_ready,
  // AXI4-Lite master
  output logic                 o_awvalid,
  output axil_pkg::axil_addr_t o_awaddr,
  input  logic                 i_awready,
  output logic                 o_wvalid,
  output axil_pkg::axil_data_t o_wdata,
  output axil_pkg::axil_strb_t o_wstrb,
  input  logic                 i_wready,
  input  logic                 i_bvalid,
  input  axil_pkg::axil_resp_t i_bresp,
  output logic                 o_bready,
  output logic                 o_arvalid,
  output axil_pkg::axil_addr_t o_araddr,
  input  logic                 i_arready,
  input  logic                 i_rvalid,
  input  axil_pkg::axil_data_t i_rdata,
  input  axil_pkg::axil_resp_t i_rresp,
  output logic                 o_rready
);
  import cmd_pkg::*;
  import axil_pkg::*;

  logic       hdr_valid;
  cmd_hdr_t   hdr;
  logic       pay_valid;
  word_t      pay_data;
  logic       pay_ready;
  logic       cmd_done;

  logic       req_valid;
  logic       req_ready;
  bus_req_t   req;
  logic       rsp_valid;
  bus_rsp_t   rsp;

  logic       cfg_we;
  word_t      cfg_addr;
  word_t      cfg_wdata;
  word_t      cfg_rdata;
  logic       wr_resp_en;
  axil_strb_t wstrb_mask;

  hdr_collector hdr_collector_inst (
    .clk         (clk),
    .w_rst       (w_rst),
    .i_in_valid  (i_in_valid),
    .i_in_data   (i_in_data),
    .o_in_ready  (o_in_ready),
    .o_hdr_valid (hdr_valid),
    .o_hdr       (hdr),
    .o_pay_valid (pay_valid),
    .o_pay_data  (pay_data),
    .i_pay_ready (pay_ready),
    .i_cmd_done  (cmd_done)
  );

  cmd_sequencer cmd_sequencer_inst (
    .clk          (clk),
    .w_rst        (w_rst),
    .i_hdr_valid  (hdr_valid),
    .i_hdr        (hdr),
    .i_pay_valid  (pay_valid),
    .i_pay_data   (pay_data),
    .o_pay_ready  (pay_ready),
    .o_cmd_done   (cmd_done),
    .o_req_valid  (req_valid),
    .o_req        (req),
    .i_req_ready  (req_ready),
    .i_rsp_valid  (rsp_valid),
    .i_rsp        (rsp),
    .o_cfg_we     (cfg_we),
    .o_cfg_addr   (cfg_addr),
    .o_cfg_wdata  (cfg_wdata),
    .i_cfg_rdata  (cfg_rdata),
    .i_wr_resp_en (wr_resp_en),
    .o_out_valid  (o_out_valid),
    .o_out_data   (o_out_data),
    .o_out_last   (o_out_last),
    .i_out_ready  (i_out_ready)
  );

  axil_port axil_port_inst (
    .clk         (clk),
    .w_rst       (w_rst),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_req_ready (req_ready),
    .o_rsp_valid (rsp_valid),
    .o_rsp       (rsp),
    .i_wstrb     (wstrb_mask),
    .o_awvalid   (o_awvalid),
    .o_awaddr    (o_awaddr),
    .i_awready   (i_awready),
    .o_wvalid    (o_wvalid),
    .o_wdata     (o_wdata),
    .o_wstrb     (o_wstrb),
    .i_wready    (i_wready),
    .i_bvalid    (i_bvalid),
    .i_bresp     (i_bresp),
    .o_bready    (o_bready),
    .o_arvalid   (o_arvalid),
    .o_araddr    (o_araddr),
    .i_arready   (i_arready),
    .i_rvalid    (i_rvalid),
    .i_rdata     (i_rdata),
    .i_rresp     (i_rresp),
    .o_rready    (o_rready)
  );

  master_cfg_regs master_cfg_regs_inst (
    .clk          (clk),
    .w_rst        (w_rst),
    .i_we         (cfg_we),
    .i_addr       (cfg_addr),
    .i_wdata      (cfg_wdata),
    .o_rdata      (cfg_rdata),
    .o_wr_resp_en (wr_resp_en),
    .o_wstrb      (wstrb_mask)
  );

endmodule

`default_nettype wire

/* hdl/master_cfg_regs.sv */
// Two registers at config addresses 0 and 1; other addresses read zero and ignore writes
`timescale 1ns/1ps
`default_nettype none

module master_cfg_regs (
  input  logic                 clk,
  input  logic                 w_rst,
  input  logic                 i_we,
  input  cmd_pkg::word_t       i_addr,
  input  cmd_pkg::word_t       i_wdata,
  output cmd_pkg::word_t       o_rdata,
  output logic                 o_wr_resp_en,
  output axil_pkg::axil_strb_t o_wstrb
);
  import cmd_pkg::*;
  import axil_pkg::*;

  logic       wr_resp_q;  // Flags register, only one bit implemented
  axil_strb_t wstrb_q;

  assign o_wr_resp_en = wr_resp_q;
  assign o_wstrb      = wstrb_q;

  always_ff @(posedge clk) begin
    if (w_rst) begin
      wr_resp_q <= 1'b0;
      wstrb_q   <= WSTRB_ALL;
    end else if (i_we) begin
      case (i_addr)
        CFG_ADDR_FLAGS: wr_resp_q <= i_wdata[CFG_FLAG_WR_RESP];
        CFG_ADDR_WSTRB: wstrb_q   <= i_wdata[$bits(axil_strb_t)-1:0];
        default: ;
      endcase
    end
  end

  // Read port follows the address in the same cycle
  always_comb begin
    o_rdata = '0;
    case (i_addr)
      CFG_ADDR_FLAGS: o_rdata[CFG_FLAG_WR_RESP] = wr_resp_q;
      CFG_ADDR_WSTRB: o_rdata[$bits(axil_strb_t)-1:0] = wstrb_q;
      default: o_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/axil_port.sv */
// One AXI4-Lite single-beat access at a time; takes a request only when idle
`timescale 1ns/1ps
`default_nettype none

module axil_port (
  input  logic                 clk,
  input  logic                 w_rst,
  input  logic                 i_req_valid,
  input  axil_pkg::bus_req_t   i_req,
  output logic                 o_req_ready,
  output logic                 o_rsp_valid,
  output axil_pkg::bus_rsp_t   o_rsp,
  input  axil_pkg::axil_strb_t i_wstrb,
  output logic                 o_awvalid,
  output axil_pkg::axil_addr_t o_awaddr,
  input  logic                 i_awready,
  output logic                 o_wvalid,
  output axil_pkg::axil_data_t o_wdata,
  output axil_pkg::axil_strb_t o_wstrb,
  input  logic                 i_wready,
  input  logic                 i_bvalid,
  input  axil_pkg::axil_resp_t i_bresp,
  output logic                 o_bready,
  output logic                 o_arvalid,
  output axil_pkg::axil_addr_t o_araddr,
  input  logic                 i_arready,
  input  logic                 i_rvalid,
  input  axil_pkg::axil_data_t i_rdata,
  input  axil_pkg::axil_resp_t i_rresp,
  output logic                 o_rready
);

  typedef enum logic [2:0] {ST_IDLE, ST_WRITE, ST_BRESP, ST_RADDR, ST_RDATA} port_state_t;

  port_state_t state;
  logic        accept;

  assign o_req_ready = (state == ST_IDLE);
  assign accept      = i_req_valid & o_req_ready;

  always_ff @(posedge clk) begin
    if (w_rst) begin
      state       <= ST_IDLE;
      o_awvalid   <= 1'b0;
      o_wvalid    <= 1'b0;
      o_bready    <= 1'b0;
      o_arvalid   <= 1'b0;
      o_rready    <= 1'b0;
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept && i_req.write) begin
            o_awvalid <= 1'b1;
            o_wvalid  <= 1'b1;
            state     <= ST_WRITE;
          end else if (accept) begin
            o_arvalid <= 1'b1;
            state     <= ST_RADDR;
          end
        end
        ST_WRITE: begin
          // Address and data may be taken in either order
          if (i_awready) o_awvalid <= 1'b0;
          if (i_wready)  o_wvalid  <= 1'b0;
          if ((i_awready || !o_awvalid) && (i_wready || !o_wvalid)) begin
            o_bready <= 1'b1;
            state    <= ST_BRESP;
          end
        end
        ST_BRESP: begin
          if (i_bvalid) begin
            o_bready    <= 1'b0;
            o_rsp_valid <= 1'b1;
            state       <= ST_IDLE;
          end
        end
        ST_RADDR: begin
          if (i_arready) begin
            o_arvalid <= 1'b0;
            o_rready  <= 1'b1;
            state     <= ST_RDATA;
          end
        end
        ST_RDATA: begin
          if (i_rvalid) begin
            o_rready    <= 1'b0;
            o_rsp_valid <= 1'b1;
            state       <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_awaddr <= i_req.addr;
      o_araddr <= i_req.addr;
      o_wdata  <= i_req.data;
      o_wstrb  <= i_req.strb & i_wstrb;  // Config mask limits the lanes
    end
    if (state == ST_BRESP && i_bvalid) o_rsp <= '{data: '0, resp: i_bresp};
    if (state == ST_RDATA && i_rvalid) o_rsp <= '{data: i_rdata, resp: i_rresp};
  end

endmodule

`default_nettype wire

/* hdl/cmd_sequencer.sv */
// Runs one command at a time; status word goes last, except bus writes with the response off
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
  input  logic               clk,
  input  logic               w_rst,
  input  logic               i_hdr_valid,
  input  cmd_pkg::cmd_hdr_t  i_hdr,
  input  logic               i_pay_valid,
  input  cmd_pkg::word_t     i_pay_data,
  output logic               o_pay_ready,
  output logic               o_cmd_done,
  output logic               o_req_valid,
  output axil_pkg::bus_req_t o_req,
  input  logic               i_req_ready,
  input  logic               i_rsp_valid,
  input  axil_pkg::bus_rsp_t i_rsp,
  output logic               o_cfg_we,
  output cmd_pkg::word_t     o_cfg_addr,
  output cmd_pkg::word_t     o_cfg_wdata,
  input  cmd_pkg::word_t     i_cfg_rdata,
  input  logic               i_wr_resp_en,
  output logic               o_out_valid,
  output cmd_pkg::word_t     o_out_data,
  output logic               o_out_last,
  input  logic               i_out_ready
);
  import cmd_pkg::*;
  import axil_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, S_BUS_WR, S_BUS_RD, S_CFG_WR, S_CFG_RD, S_DROP, S_STATUS
  } seq_state_t;

  seq_state_t  state;
  word_t       addr_q;
  word_t       cnt_q;       // Words still to move
  logic [2:0]  step_q;      // 0, 1 or 4
  cmd_status_t status_q;
  cmd_status_t hdr_status;
  logic        cfg_sel;
  logic        rsp_wait;
  logic        bus_busy;
  logic        words_left;
  logic        out_free;
  logic        pay_take;
  logic        wr_issue;
  logic        rd_issue;
  logic        load_rd;
  logic        load_cfg;
  logic        load_sts;

  assign cfg_sel    = i_hdr.flags[FLAG_CFG_SPACE];
  assign bus_busy   = o_req_valid | rsp_wait;
  assign words_left = (cnt_q != '0);
  assign out_free   = ~o_out_valid | i_out_ready;

  // Status bits known from the header alone
  always_comb begin
    hdr_status          = '0;
    hdr_status.complete = 1'b1;
    case (i_hdr.command)
      CMD_PING: hdr_status.ping = 1'b1;
      CMD_WRITE: begin
        hdr_status.write     = ~cfg_sel;
        hdr_status.cfg_write = cfg_sel;
      end
      CMD_READ: begin
        hdr_status.read     = ~cfg_sel;
        hdr_status.cfg_read = cfg_sel;
      end
      default: hdr_status.unrec = 1'b1;
    endcase
  end

  always_comb begin
    case (state)
      S_BUS_WR:         o_pay_ready = words_left & ~bus_busy;
      S_CFG_WR, S_DROP: o_pay_ready = words_left;
      default:          o_pay_ready = 1'b0;
    endcase
  end

  assign pay_take = o_pay_ready & i_pay_valid;
  assign wr_issue = (state == S_BUS_WR) & pay_take;
  // Egress must be empty so the read data has a place to land
  assign rd_issue = (state == S_BUS_RD) & words_left & ~bus_busy & ~o_out_valid;
  assign load_rd  = (state == S_BUS_RD) & i_rsp_valid;
  assign load_cfg = (state == S_CFG_RD) & words_left & out_free;
  assign load_sts = (state == S_STATUS) & ~o_out_valid;

  assign o_cfg_we    = (state == S_CFG_WR) & pay_take;
  assign o_cfg_addr  = addr_q;
  assign o_cfg_wdata = i_pay_data;

  always_ff @(posedge clk) begin
    if (w_rst) begin
      state       <= S_IDLE;
      cnt_q       <= '0;
      o_req_valid <= 1'b0;
      rsp_wait    <= 1'b0;
      o_out_valid <= 1'b0;
      o_out_last  <= 1'b0;
      o_cmd_done  <= 1'b0;
    end else begin
      o_cmd_done <= 1'b0;
      if (o_out_valid && i_out_ready) begin
        o_out_valid <= 1'b0;
        o_out_last  <= 1'b0;
      end
      if (o_req_valid && i_req_ready) begin
        o_req_valid <= 1'b0;
        rsp_wait    <= 1'b1;
      end
      if (i_rsp_valid) rsp_wait <= 1'b0;
      if (wr_issue || rd_issue) o_req_valid <= 1'b1;
      if (pay_take || rd_issue || load_cfg) cnt_q <= cnt_q - 32'd1;
      if (load_rd || load_cfg || load_sts) begin
        o_out_valid <= 1'b1;
        o_out_last  <= load_sts;
      end

      case (state)
        S_IDLE: begin
          if (i_hdr_valid) begin
            cnt_q <= i_hdr.count;
            if (hdr_status.ping)           state <= S_STATUS;
            else if (hdr_status.write)     state <= S_BUS_WR;
            else if (hdr_status.read)      state <= S_BUS_RD;
            else if (hdr_status.cfg_write) state <= S_CFG_WR;
            else if (hdr_status.cfg_read)  state <= S_CFG_RD;
            else                           state <= S_DROP;
          end
        end
        S_BUS_WR: begin
          if (!words_left && !bus_busy) begin
            if (i_wr_resp_en) begin
              state <= S_STATUS;
            end else begin
              o_cmd_done <= 1'b1;  // Silent write
              state      <= S_IDLE;
            end
          end
        end
        S_BUS_RD, S_CFG_WR, S_CFG_RD, S_DROP: begin
          if (!words_left && !bus_busy) state <= S_STATUS;
        end
        S_STATUS: begin
          if (o_out_valid && o_out_last && i_out_ready) begin
            o_cmd_done <= 1'b1;
            state      <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && i_hdr_valid) begin
      addr_q   <= i_hdr.address;
      status_q <= hdr_status;
      if (i_hdr.flags[FLAG_ADDR_FIXED]) step_q <= 3'd0;
      else                              step_q <= cfg_sel ? 3'd1 : 3'd4;
    end else if (pay_take || rd_issue || load_cfg) begin
      addr_q <= addr_q + word_t'(step_q);
    end
    if (i_rsp_valid && i_rsp.resp > status_q.bus_status) begin
      status_q.bus_status <= i_rsp.resp;  // Keep the worst
    end
    if (wr_issue) begin
      o_req <= '{write: 1'b1, addr: addr_q, data: i_pay_data, strb: WSTRB_ALL};
    end else if (rd_issue) begin
      o_req <= '{write: 1'b0, addr: addr_q, data: '0, strb: '0};
    end
    if (load_rd)       o_out_data <= i_rsp.data;
    else if (load_cfg) o_out_data <= i_cfg_rdata;
    else if (load_sts) o_out_data <= status_q;
  end

endmodule

`default_nettype wire

/* hdl/hdr_collector.sv */
// Takes one header word per cycle; payload length is not checked here, the sequencer ends it
`timescale 1ns/1ps
`default_nettype none

module hdr_collector (
  input  logic              clk,
  input  logic              w_rst,
  input  logic              i_in_valid,
  input  cmd_pkg::word_t    i_in_data,
  output logic              o_in_ready,
  output logic              o_hdr_valid,
  output cmd_pkg::cmd_hdr_t o_hdr,
  output logic              o_pay_valid,
  output cmd_pkg::word_t    o_pay_data,
  input  logic              i_pay_ready,
  input  logic              i_cmd_done
);
  import cmd_pkg::*;

  typedef enum logic [1:0] {ST_HDR, ST_ANNOUNCE, ST_PAYLOAD} col_state_t;

  col_state_t state;
  col_state_t state_nxt;
  logic [1:0] word_cnt;
  logic       hdr_rdy_q;  // Ready while gathering the header
  logic       take_hdr;
  cmd_hdr_t   hdr_q;

  assign take_hdr    = hdr_rdy_q & i_in_valid;
  assign o_in_ready  = hdr_rdy_q | ((state == ST_PAYLOAD) & i_pay_ready);
  assign o_hdr_valid = (state == ST_ANNOUNCE);
  assign o_hdr       = hdr_q;
  assign o_pay_valid = (state == ST_PAYLOAD) & i_in_valid;
  assign o_pay_data  = i_in_data;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_HDR:      if (take_hdr && word_cnt == 2'(HDR_WORDS - 1)) state_nxt = ST_ANNOUNCE;
      ST_ANNOUNCE: state_nxt = ST_PAYLOAD;
      ST_PAYLOAD:  if (i_cmd_done) state_nxt = ST_HDR;
      default:     state_nxt = ST_HDR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (w_rst) begin
      state     <= ST_HDR;
      word_cnt  <= '0;
      hdr_rdy_q <= 1'b0;
    end else begin
      state     <= state_nxt;
      hdr_rdy_q <= (state_nxt == ST_HDR);
      if (take_hdr) begin
        word_cnt <= (word_cnt == 2'(HDR_WORDS - 1)) ? 2'd0 : word_cnt + 2'd1;
      end
    end
  end

  // First word ends up in the top 32 bits
  always_ff @(posedge clk) begin
    if (take_hdr) hdr_q <= {hdr_q[63:0], i_in_data};
  end

endmodule

`default_nettype wire

/* hdl/axil_pkg.sv */
// AXI4-Lite types for a 32-bit data, 32-bit address bus; no IDs, bursts or prot
`default_nettype none

package axil_pkg;

  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'd0;
  localparam axil_resp_t RESP_SLVERR = 2'd2;
  localparam axil_resp_t RESP_DECERR = 2'd3;

  localparam axil_strb_t WSTRB_ALL = 4'hF;  // All four byte lanes

  // Single-word request from the sequencer
  typedef struct packed {
    logic       write;
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
  } bus_req_t;

  // Read data is zero for writes
  typedef struct packed {
    axil_data_t data;
    axil_resp_t resp;
  } bus_rsp_t;

endpackage

`default_nettype wire

/* hdl/cmd_pkg.sv */
// Command protocol shared by the collector and sequencer; header is always three 32-bit words
`default_nettype none

package cmd_pkg;

  typedef logic [31:0] word_t;     // Stream and register word
  typedef logic [15:0] cmd_code_t;
  typedef logic [15:0] cmd_flags_t;

  // Command codes, anything else is unrecognized
  localparam cmd_code_t CMD_PING  = 16'd0;
  localparam cmd_code_t CMD_WRITE = 16'd1;
  localparam cmd_code_t CMD_READ  = 16'd2;

  // Bit positions in cmd_flags_t
  localparam int FLAG_CFG_SPACE  = 0;  // Target the master's own registers
  localparam int FLAG_ADDR_FIXED = 1;  // No address increment

  // Word 0 = {command, flags}, word 1 = count, word 2 = address
  typedef struct packed {
    cmd_code_t  command;
    cmd_flags_t flags;
    word_t      count;
    word_t      address;
  } cmd_hdr_t;

  // Status word, bit 0 first from the bottom
  typedef struct packed {
    logic [22:0] unused;
    logic        unrec;
    logic [1:0]  bus_status;  // Worst AXI response of the command
    logic        cfg_read;
    logic        cfg_write;
    logic        read;
    logic        write;
    logic        ping;
    logic        complete;
  } cmd_status_t;

  localparam int HDR_WORDS = 3;

  // Configuration space map
  localparam word_t CFG_ADDR_FLAGS = 32'd0;
  localparam word_t CFG_ADDR_WSTRB = 32'd1;
  localparam int    CFG_FLAG_WR_RESP = 0;  // Status word after bus writes

endpackage

`default_nettype wire
